//--- include/eeprom_macros.svh
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

// byte address, 2048 bytes in 8 blocks of 256
`define EE_ADDR_W 11

`define EE_DATA_W 8

// upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// CLK cycles per quarter SCL period
`define EE_SCL_DIV 4

`endif

//--- hw/eeprom_pkg.sv
`include "eeprom_macros.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_data_t;

    // one host operation
    typedef struct packed
    {
        logic     write;
        ee_addr_t addr;
        ee_data_t wdata;
    } ee_req_t;

    typedef struct packed
    {
        ee_data_t rdata;
        logic     nack;   // any byte not acknowledged
    } ee_rsp_t;

    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_TX,
        CMD_RX
    } bus_cmd_t;

    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } ctrl_state_t;

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_CTRL,
        S_ADDR,
        S_WDATA,
        S_RDATA,
        S_ACK
    } slave_state_t;

endpackage

//--- hw/i2c_bit_engine.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 go,
    input  eeprom_pkg::bus_cmd_t cmd,
    input  eeprom_pkg::ee_data_t tx_byte,
    input  logic                 master_nack,
    output logic                 done,
    output eeprom_pkg::ee_data_t rx_byte,
    output logic                 slave_nack,
    output logic                 scl,
    output logic                 sda_low,
    input  logic                 sda
);
    import eeprom_pkg::*;

    localparam int QW  = $clog2(`EE_SCL_DIV);
    localparam int MSB = `EE_DATA_W - 1;

    logic          busy;
    bus_cmd_t      cmd_q;
    logic          nack_q;    // ack bit sent after a received byte
    logic [QW-1:0] q_cnt;
    logic [1:0]    phase;     // SCL quarter: 0 low, 1-2 high, 3 low (high for stop)
    logic [3:0]    bit_cnt;   // 0-7 data, 8 ack
    ee_data_t      shreg;
    logic          q_last;
    logic          bit_last;
    logic [1:0]    nxt_phase;
    logic [3:0]    nxt_bit;
    logic          nxt_msb;

    function automatic logic scl_level(bus_cmd_t c, logic [1:0] ph);
        return (ph == 2'd1) || (ph == 2'd2) || (c == CMD_STOP && ph == 2'd3);
    endfunction

    function automatic logic sda_pull(bus_cmd_t c, logic [1:0] ph, logic [3:0] b,
                                      logic msb, logic mn);
        logic low;
        case (c)
            CMD_START: low = ph[1];   // falls in the middle of SCL high
            CMD_STOP:  low = ~ph[1];  // rises in the middle of SCL high
            CMD_TX:    low = (b < 4'd8) ? ~msb : 1'b0;
            default:   low = (b < 4'd8) ? 1'b0 : ~mn;
        endcase
        return low;
    endfunction

    assign q_last   = (q_cnt == QW'(`EE_SCL_DIV - 1));
    assign bit_last = (cmd_q == CMD_TX || cmd_q == CMD_RX) ? (bit_cnt == 4'd8) : 1'b1;
    assign done     = busy && q_last && (phase == 2'd3) && bit_last;
    assign rx_byte  = shreg;

    always_comb
    begin
        nxt_phase = phase + 2'd1;
        nxt_bit   = (phase == 2'd3) ? bit_cnt + 4'd1 : bit_cnt;
        nxt_msb   = (phase == 2'd3) ? shreg[MSB-1] : shreg[MSB]; // shift lands at bit end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy       <= 1'b0;
            q_cnt      <= '0;
            phase      <= 2'd0;
            bit_cnt    <= 4'd0;
            slave_nack <= 1'b0;
            scl        <= 1'b1;
            sda_low    <= 1'b0;
        end
        else if (!busy)
        begin
            if (go)
            begin
                busy       <= 1'b1;
                q_cnt      <= '0;
                phase      <= 2'd0;
                bit_cnt    <= 4'd0;
                slave_nack <= 1'b0;
                scl        <= scl_level(cmd, 2'd0);
                sda_low    <= sda_pull(cmd, 2'd0, 4'd0, tx_byte[MSB], master_nack);
            end
        end
        else
        begin
            q_cnt <= q_cnt + 1'b1;
            if (q_last)
            begin
                q_cnt <= '0;
                if (cmd_q == CMD_TX && phase == 2'd1 && bit_cnt == 4'd8)
                begin
                    slave_nack <= sda;    // mid-high ack sample
                end
                if (done)
                begin
                    busy <= 1'b0;         // scl and sda held until next go
                end
                else
                begin
                    phase   <= nxt_phase;
                    bit_cnt <= nxt_bit;
                    scl     <= scl_level(cmd_q, nxt_phase);
                    sda_low <= sda_pull(cmd_q, nxt_phase, nxt_bit, nxt_msb, nack_q);
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && go)
        begin
            cmd_q  <= cmd;
            nack_q <= master_nack;
            shreg  <= tx_byte;
        end
        else if (busy && q_last)
        begin
            if (cmd_q == CMD_RX && phase == 2'd1 && bit_cnt < 4'd8)
            begin
                shreg <= {shreg[MSB-1:0], sda};
            end
            else if (cmd_q == CMD_TX && phase == 2'd3)
            begin
                shreg <= {shreg[MSB-1:0], 1'b0};
            end
        end
    end

endmodule

//--- hw/eeprom_ctrl.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module eeprom_ctrl
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req,
    input  eeprom_pkg::ee_req_t  req_data,
    output logic                 ack,
    output eeprom_pkg::ee_rsp_t  rsp,
    output logic                 go,
    output eeprom_pkg::bus_cmd_t cmd,
    output eeprom_pkg::ee_data_t tx_byte,
    output logic                 master_nack,
    input  logic                 done,
    input  eeprom_pkg::ee_data_t rx_byte,
    input  logic                 slave_nack
);
    import eeprom_pkg::*;

    ctrl_state_t state;
    ctrl_state_t nxt;
    ee_req_t     req_q;
    logic        issue;   // entering a state that runs a bus operation

    function automatic bus_cmd_t cmd_of(ctrl_state_t s);
        case (s)
            START, RESTART: return CMD_START;
            DATA_R:         return CMD_RX;
            STOP:           return CMD_STOP;
            default:        return CMD_TX;
        endcase
    endfunction

    function automatic ee_data_t byte_of(ctrl_state_t s);
        case (s)
            CTRL_W:  return {`EE_DEV_CODE, req_q.addr[`EE_ADDR_W-1 -: 3], 1'b0};
            CTRL_R:  return {`EE_DEV_CODE, req_q.addr[`EE_ADDR_W-1 -: 3], 1'b1};
            ADDR:    return req_q.addr[7:0];
            DATA_W:  return req_q.wdata;
            default: return '0;
        endcase
    endfunction

    always_comb
    begin
        nxt = state;
        case (state)
            IDLE:    if (req) nxt = START;
            START:   if (done) nxt = CTRL_W;
            CTRL_W:  if (done) nxt = slave_nack ? STOP : ADDR;
            ADDR:
            begin
                if (done)
                begin
                    if (slave_nack)
                        nxt = STOP;
                    else
                        nxt = req_q.write ? DATA_W : RESTART;
                end
            end
            DATA_W:  if (done) nxt = STOP;
            RESTART: if (done) nxt = CTRL_R;
            CTRL_R:  if (done) nxt = slave_nack ? STOP : DATA_R;
            DATA_R:  if (done) nxt = STOP;
            STOP:    if (done) nxt = DONE;
            DONE:    if (!req) nxt = IDLE;  // hold ack until host lets go
            default: nxt = IDLE;
        endcase
    end

    assign issue = (nxt != state) && !(nxt inside {IDLE, DONE});
    assign ack   = (state == DONE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            go    <= 1'b0;
        end
        else
        begin
            state <= nxt;
            go    <= issue;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && req)
        begin
            req_q <= req_data;
            rsp   <= '0;
        end
        else if (done)
        begin
            if (slave_nack)
                rsp.nack <= 1'b1;
            if (state == DATA_R)
                rsp.rdata <= rx_byte;
        end

        if (issue)
        begin
            cmd         <= cmd_of(nxt);
            tx_byte     <= byte_of(nxt);
            master_nack <= (nxt == DATA_R); // single byte, so always NACK
        end
    end

endmodule

//--- hw/eeprom_slave.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module eeprom_slave
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic wp,
    output logic sda_low
);
    import eeprom_pkg::*;

    localparam int DEPTH = 1 << `EE_ADDR_W;
    localparam int MSB   = `EE_DATA_W - 1;

    ee_data_t     mem [DEPTH];
    slave_state_t state;
    slave_state_t ack_next;
    slave_state_t nxt_after;
    logic         scl_r1;
    logic         scl_r2;
    logic         sda_r1;
    logic         sda_r2;
    logic         rise;
    logic         fall;
    logic         start_cond;
    logic         stop_cond;
    logic         receiving;
    logic         byte_in;
    logic         byte_ack;
    logic [3:0]   bit_cnt;
    ee_data_t     shreg;
    ee_addr_t     ptr;

    assign rise       = ~scl_r2 & scl_r1;
    assign fall       = scl_r2 & ~scl_r1;
    assign start_cond = scl_r1 & scl_r2 & sda_r2 & ~sda_r1;
    assign stop_cond  = scl_r1 & scl_r2 & ~sda_r2 & sda_r1;
    assign receiving  = state inside {S_CTRL, S_ADDR, S_WDATA};
    assign byte_in    = receiving && fall && (bit_cnt == 4'd8);

    // ack decision for the byte just shifted in
    always_comb
    begin
        byte_ack  = 1'b0;
        nxt_after = S_IDLE;
        case (state)
            S_CTRL:
            begin
                byte_ack  = (shreg[MSB -: 4] == `EE_DEV_CODE);
                nxt_after = shreg[0] ? S_RDATA : S_ADDR;
            end
            S_ADDR:
            begin
                byte_ack  = 1'b1;
                nxt_after = S_WDATA;
            end
            S_WDATA:
            begin
                byte_ack  = !wp;
                nxt_after = S_WDATA;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_r1   <= 1'b1;
            scl_r2   <= 1'b1;
            sda_r1   <= 1'b1;
            sda_r2   <= 1'b1;
            state    <= S_IDLE;
            ack_next <= S_IDLE;
            bit_cnt  <= 4'd0;
            sda_low  <= 1'b0;
        end
        else
        begin
            scl_r1 <= scl;
            scl_r2 <= scl_r1;
            sda_r1 <= sda;
            sda_r2 <= sda_r1;
            if (start_cond)
            begin
                state   <= S_CTRL;  // also covers repeated start
                bit_cnt <= 4'd0;
                sda_low <= 1'b0;
            end
            else if (stop_cond)
            begin
                state   <= S_IDLE;
                sda_low <= 1'b0;
            end
            else
            begin
                case (state)
                    S_CTRL, S_ADDR, S_WDATA:
                    begin
                        if (rise)
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                        else if (byte_in)
                        begin
                            if (byte_ack)
                            begin
                                sda_low  <= 1'b1;
                                state    <= S_ACK;
                                ack_next <= nxt_after;
                            end
                            else
                            begin
                                state <= S_IDLE;  // NACK, line left released
                            end
                        end
                    end
                    S_ACK:
                    begin
                        if (fall)
                        begin
                            state   <= ack_next;
                            bit_cnt <= 4'd0;
                            sda_low <= (ack_next == S_RDATA) ? ~mem[ptr][MSB] : 1'b0;
                        end
                    end
                    S_RDATA:
                    begin
                        if (fall)
                        begin
                            if (bit_cnt == 4'd7)
                            begin
                                sda_low <= 1'b0;  // master ack slot
                                state   <= S_IDLE;
                            end
                            else
                            begin
                                sda_low <= ~shreg[MSB-1];
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (receiving && rise)
            shreg <= {shreg[MSB-1:0], sda_r1};
        else if (state == S_ACK && fall && ack_next == S_RDATA)
            shreg <= mem[ptr];
        else if (state == S_RDATA && fall)
            shreg <= {shreg[MSB-1:0], 1'b0};

        if (byte_in && byte_ack)
        begin
            if (state == S_CTRL && !shreg[0])
                ptr[`EE_ADDR_W-1:8] <= shreg[3:1];  // block bits
            if (state == S_ADDR)
                ptr[7:0] <= shreg;
            if (state == S_WDATA)
                mem[ptr] <= shreg;
        end
    end

endmodule

//--- hw/eeprom_subsys.sv
`timescale 1ns/1ps

module eeprom_subsys
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                req,
    input  eeprom_pkg::ee_req_t req_data,
    input  logic                wp,
    output logic                ack,
    output eeprom_pkg::ee_rsp_t rsp
);
    import eeprom_pkg::*;

    logic     go;
    logic     done;
    bus_cmd_t cmd;
    ee_data_t tx_byte;
    ee_data_t rx_byte;
    logic     master_nack;
    logic     slave_nack;
    logic     scl;
    logic     sda;
    logic     m_sda_low;
    logic     s_sda_low;

    // open-drain line, high unless someone pulls
    assign sda = ~(m_sda_low | s_sda_low);

    eeprom_ctrl eeprom_ctrl_inst
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .req         (req),
        .req_data    (req_data),
        .ack         (ack),
        .rsp         (rsp),
        .go          (go),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .master_nack (master_nack),
        .done        (done),
        .rx_byte     (rx_byte),
        .slave_nack  (slave_nack)
    );

    i2c_bit_engine i2c_bit_engine_inst
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .go          (go),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .master_nack (master_nack),
        .done        (done),
        .rx_byte     (rx_byte),
        .slave_nack  (slave_nack),
        .scl         (scl),
        .sda_low     (m_sda_low),
        .sda         (sda)
    );

    eeprom_slave eeprom_slave_inst
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .scl     (scl),
        .sda     (sda),
        .wp      (wp),
        .sda_low (s_sda_low)
    );

endmodule

//--- dv/eeprom_subsys_tb.sv
`timescale 1ns/1ps

module eeprom_subsys_tb;
    import eeprom_pkg::*;

    localparam int CYCLES_PER_OP = 900;
    localparam int RESET_CYCLES  = 8;

    logic        CLK;
    logic        RESET;
    logic        req;
    ee_req_t     req_data;
    logic        wp;
    logic        ack;
    ee_rsp_t     rsp;

    logic        op_write  [$];
    logic        op_wp     [$];
    ee_addr_t    op_addr   [$];
    ee_data_t    op_wdata  [$];
    ee_data_t    exp_rdata [$];
    logic        exp_nack  [$];
    logic        ops_loaded;
    int          errors;
    int          checks;
    logic [31:0] rng;

    eeprom_subsys eeprom_subsys_inst
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .req_data (req_data),
        .wp       (wp),
        .ack      (ack),
        .rsp      (rsp)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0 to 7 idle cycles
    function automatic int rand_gap();
        rng = xorshift32(rng);
        return int'(rng % 32'd8);
    endfunction

    // one step, lands just after the rising edge
    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp, int op);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] op %0d %s: got 0x%0h expected 0x%0h", op, name, got, exp);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_write;
        logic [31:0] f_wp;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        logic [31:0] f_nack;
        fd = $fopen("dv/eeprom_golden.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open dv/eeprom_golden.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#")
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                f_write, f_wp, f_addr, f_wdata, f_rdata, f_nack);
                    if (n == 6)
                    begin
                        op_write.push_back(f_write[0]);
                        op_wp.push_back(f_wp[0]);
                        op_addr.push_back(ee_addr_t'(f_addr));
                        op_wdata.push_back(ee_data_t'(f_wdata));
                        exp_rdata.push_back(ee_data_t'(f_rdata));
                        exp_nack.push_back(f_nack[0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(int i);
        int gap;
        int hold;
        gap = rand_gap();
        repeat (gap) tick();
        req_data.write = op_write[i];
        req_data.addr  = op_addr[i];
        req_data.wdata = op_wdata[i];
        wp             = op_wp[i];
        req            = 1'b1;
        tick();
        while (!ack) tick();  // watchdog bounds this
        check_value("rsp.rdata", 32'(rsp.rdata), 32'(exp_rdata[i]), i);
        check_value("rsp.nack", 32'(rsp.nack), 32'(exp_nack[i]), i);

        // response holds while the host keeps req up
        hold = rand_gap();
        repeat (hold)
        begin
            tick();
            check_value("ack", 32'(ack), 32'd1, i);
            check_value("rsp.rdata", 32'(rsp.rdata), 32'(exp_rdata[i]), i);
            check_value("rsp.nack", 32'(rsp.nack), 32'(exp_nack[i]), i);
        end
        req = 1'b0;
        tick();
        check_value("ack", 32'(ack), 32'd0, i);
    endtask

    initial
    begin
        int n_ops;
        RESET      = 1'b1;
        req        = 1'b0;
        req_data   = '0;
        wp         = 1'b0;
        errors     = 0;
        checks     = 0;
        rng        = 32'd72860;
        ops_loaded = 1'b0;
        load_golden();
        n_ops      = op_write.size();
        ops_loaded = 1'b1;
        repeat (RESET_CYCLES) tick();
        RESET = 1'b0;
        if (n_ops == 0)
        begin
            errors++;
            $display("no operations found in the golden file");
        end
        for (int i = 0; i < n_ops; i++)
            run_op(i);
        repeat (2) tick();
        $display("errors: %0d, checks: %0d, operations: %0d", errors, checks, n_ops);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        int limit;
        wait (ops_loaded);
        limit = op_write.size() * CYCLES_PER_OP + RESET_CYCLES + 16;
        repeat (limit) @(posedge CLK);
        $display("timeout: operations did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- dv/eeprom_golden.txt
# columns (hex): write wp addr wdata exp_rdata exp_nack
# write=1 stores wdata, write=0 reads back; writes expect rdata 00
1 0 000 a5 00 0
0 0 000 00 a5 0
1 0 0ff ff 00 0
0 0 0ff 00 ff 0
1 0 055 10 00 0
1 0 155 21 00 0
1 0 255 32 00 0
1 0 355 43 00 0
1 0 455 54 00 0
1 0 555 65 00 0
1 0 655 76 00 0
1 0 755 87 00 0
0 0 055 00 10 0
0 0 155 00 21 0
0 0 255 00 32 0
0 0 355 00 43 0
0 0 455 00 54 0
0 0 555 00 65 0
0 0 655 00 76 0
0 0 755 00 87 0
1 0 155 c9 00 0
0 0 155 00 c9 0
0 0 055 00 10 0
1 1 255 ee 00 1
0 1 255 00 32 0
0 0 000 00 a5 0
1 0 7ff 81 00 0
0 0 7ff 00 81 0

//--- verilog.f
+incdir+include
hw/eeprom_pkg.sv
hw/i2c_bit_engine.sv
hw/eeprom_ctrl.sv
hw/eeprom_slave.sv
hw/eeprom_subsys.sv
dv/eeprom_subsys_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module eeprom_subsys_tb \
    -Mdir obj_dir -o eeprom_subsys_tb_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/eeprom_subsys_tb_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation did not exit cleanly"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
